// ==== Makefile ====
TOP = fifo_burst_drain_tb
LOG = sim.log

.PHONY: run lint clean

run:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// ==== all.f ====
logic/fifo_burst_pkg.sv
logic/sync_fifo.sv
logic/beat_counter.sv
logic/drain_fsm.sv
logic/beat_framer.sv
logic/fifo_burst_drain.sv
tests/fifo_burst_drain_tb.sv

// ==== logic/beat_counter.sv ====
// counter of beats left in a burst plus the idle timer that forces a partial burst
`timescale 1ns/1ns
`default_nettype none

module beat_counter #(
   parameter int BURST_LEN  = 4,   // longest burst in beats
   parameter int IDLE_LIMIT = 12   // idle cycles before a partial burst goes out
) (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           load,          // a new burst starts
   input  logic [$clog2(BURST_LEN+1)-1:0] load_count,    // its length in beats
   input  logic                           pop,           // one beat leaves the FIFO
   input  logic                           push,          // host activity, restarts the idle timer
   input  logic                           empty,
   output logic                           burst_done,    // with the last pop of the burst
   output logic                           idle_expired   // words have waited long enough
);

   localparam int CW = $clog2(BURST_LEN + 1);
   localparam int IW = $clog2(IDLE_LIMIT + 1);
   localparam logic [IW-1:0] IDLE_MAX = IW'(IDLE_LIMIT);

   logic [CW-1:0] remain;    // pops still owed in the running burst
   logic [IW-1:0] idle_cnt;  // cycles with stored words and no push

   // ==============================
   // beats left in the burst
   // ==============================

   // a load wins over a pop in the same cycle
   // the drain FSM does that when it chains a flush straight onto a finished burst
   always_ff @(posedge clk) begin
      if (reset) begin
         remain <= '0;
      end else if (load) begin
         remain <= load_count;
      end else if (pop && (remain != '0)) begin
         remain <= remain - CW'(1);
      end
   end

   // high only in the cycle of the final pop, so the FSM can tag it
   assign burst_done = pop & (remain == CW'(1));

   // ==============================
   // idle timer
   // ==============================

   always_ff @(posedge clk) begin
      if (reset) begin
         idle_cnt <= '0;
      end else if (push || load || empty) begin
         idle_cnt <= '0;  // activity or nothing stored means no one is waiting
      end else if (idle_cnt != IDLE_MAX) begin
         idle_cnt <= idle_cnt + IW'(1);  // saturates at the limit until a burst loads
      end
   end

   assign idle_expired = (idle_cnt == IDLE_MAX);

endmodule : beat_counter

`default_nettype wire

// ==== logic/beat_framer.sv ====
// output register stage that pairs each popped word with its last tag
`timescale 1ns/1ns
`default_nettype none

module beat_framer (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              rd_valid,    // FIFO read strobe
   input  logic [fifo_burst_pkg::WORD_W-1:0] rd_data,     // FIFO read word
   input  logic                              pop_last,    // from the FSM, one cycle ahead of rd_data
   output logic                              beat_valid,  // one strobe per beat
   output fifo_burst_pkg::beat_t             beat
);

   logic pop_last_q;  // last tag lined up with rd_data

   // ==============================
   // tag alignment
   // ==============================

   // the FIFO answers a pop one cycle later, so the tag waits one cycle too
   always_ff @(posedge clk) begin
      if (reset) begin
         pop_last_q <= 1'b0;
      end else begin
         pop_last_q <= pop_last;
      end
   end

   // ==============================
   // beat register
   // ==============================

   always_ff @(posedge clk) begin
      if (reset) begin
         beat_valid <= 1'b0;
      end else begin
         beat_valid <= rd_valid;  // pop to beat is two cycles in total
      end
   end

   // payload only means something while beat_valid is high
   always_ff @(posedge clk) begin
      if (rd_valid) begin
         beat.data <= rd_data;
         beat.last <= pop_last_q;
      end
   end

endmodule : beat_framer

`default_nettype wire

// ==== logic/drain_fsm.sv ====
// drain FSM that picks the burst cause, sizes the burst and issues the pops
`timescale 1ns/1ns
`default_nettype none

module drain_fsm #(
   parameter int FIFO_DEPTH = 16,
   parameter int BURST_LEN  = 4
) (
   input  logic                           clk,
   input  logic                           reset,
   input  logic [$clog2(FIFO_DEPTH):0]    level,         // FIFO fill level
   input  logic                           empty,
   input  logic                           busy,          // FIFO still in its reset window
   input  logic                           flush,         // one-cycle host pulse
   input  logic                           burst_done,    // from the counter, marks the last pop
   input  logic                           idle_expired,  // from the idle timer
   output logic                           load,          // start a burst this cycle
   output logic [$clog2(BURST_LEN+1)-1:0] load_count,    // its length
   output logic                           pop,
   output logic                           pop_last       // travels with the last pop
);
   import fifo_burst_pkg::*;

   localparam int LW = $clog2(FIFO_DEPTH) + 1;
   localparam int CW = $clog2(BURST_LEN + 1);
   localparam logic [LW-1:0] BURST_LVL = LW'(BURST_LEN);
   localparam logic [CW-1:0] BURST_CNT = CW'(BURST_LEN);

   drain_state_e  state;
   drain_state_e  state_next;
   logic          full_ready;  // enough words for a whole burst
   logic [CW-1:0] level_cap;   // min(level, BURST_LEN)
   logic [LW-1:0] rest_lvl;    // words left once this cycle's pop is gone
   logic [CW-1:0] rest_cap;    // min(rest_lvl, BURST_LEN)
   logic          flush_held;  // a flush is waiting or arrives right now

   // ==============================
   // burst sizing
   // ==============================

   assign full_ready = (level >= BURST_LVL);
   assign level_cap  = full_ready ? BURST_CNT : CW'(level);

   // the last pop of a burst has not left the level count yet, so take it off here
   assign rest_lvl = level - LW'(1);
   assign rest_cap = (rest_lvl >= BURST_LVL) ? BURST_CNT : CW'(rest_lvl);

   assign flush_held = (state == FLUSH_WAIT) | flush;

   // ==============================
   // state register
   // ==============================

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= IDLE;
      end else begin
         state <= state_next;
      end
   end

   // ==============================
   // next state and burst load
   // ==============================

   always_comb begin
      state_next = state;
      load       = 1'b0;
      load_count = '0;
      case (state)
         IDLE: begin
            // a flush on an empty FIFO falls through here and is forgotten
            if (!busy && !empty && (full_ready || flush || idle_expired)) begin
               load       = 1'b1;
               load_count = level_cap;
               state_next = BURST;
            end
         end
         BURST, FLUSH_WAIT: begin
            if (burst_done) begin
               state_next = IDLE;
               // serve a waiting flush right away so its beats follow without a gap
               if (flush_held && (rest_lvl != '0)) begin
                  load       = 1'b1;
                  load_count = rest_cap;
                  state_next = BURST;
               end
            end else if (flush) begin
               state_next = FLUSH_WAIT;  // hold it until the running burst ends
            end
         end
         default: state_next = IDLE;
      endcase
   end

   // pops run back to back for as long as a burst is open
   assign pop      = (state != IDLE);
   assign pop_last = pop & burst_done;

endmodule : drain_fsm

`default_nettype wire

// ==== logic/fifo_burst_drain.sv ====
// top level wiring the FIFO, beat counter, drain FSM and beat framer together
`timescale 1ns/1ns
`default_nettype none

module fifo_burst_drain #(
   parameter int FIFO_DEPTH = 16,  // power of two
   parameter int BURST_LEN  = 4,   // beats in a full burst
   parameter int IDLE_LIMIT = 12   // idle cycles before a partial burst
) (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              push,
   input  logic [fifo_burst_pkg::WORD_W-1:0] push_data,
   input  logic                              flush,       // one-cycle pulse
   output logic                              full,        // only overflow indication the host gets
   output logic                              beat_valid,
   output fifo_burst_pkg::beat_t             beat
);
   import fifo_burst_pkg::*;

   localparam int LW = $clog2(FIFO_DEPTH) + 1;
   localparam int CW = $clog2(BURST_LEN + 1);

   // ==============================
   // internal nets
   // ==============================

   logic [WORD_W-1:0] rd_data;       // FIFO to framer
   logic              rd_valid;
   logic              empty;         // FIFO status to FSM and counter
   logic [LW-1:0]     level;
   logic              busy;
   logic              pop;           // FSM to FIFO and counter
   logic              pop_last;      // FSM to framer
   logic              load;          // FSM to counter
   logic [CW-1:0]     load_count;
   logic              burst_done;    // counter back to FSM
   logic              idle_expired;

   sync_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_fifo (
      .clk       (clk),
      .reset     (reset),
      .push      (push),
      .push_data (push_data),
      .pop       (pop),
      .rd_data   (rd_data),
      .rd_valid  (rd_valid),
      .full      (full),
      .empty     (empty),
      .level     (level),
      .busy      (busy)
   );

   beat_counter #(
      .BURST_LEN  (BURST_LEN),
      .IDLE_LIMIT (IDLE_LIMIT)
   ) u_counter (
      .clk          (clk),
      .reset        (reset),
      .load         (load),
      .load_count   (load_count),
      .pop          (pop),
      .push         (push),
      .empty        (empty),
      .burst_done   (burst_done),
      .idle_expired (idle_expired)
   );

   drain_fsm #(
      .FIFO_DEPTH (FIFO_DEPTH),
      .BURST_LEN  (BURST_LEN)
   ) u_fsm (
      .clk          (clk),
      .reset        (reset),
      .level        (level),
      .empty        (empty),
      .busy         (busy),
      .flush        (flush),
      .burst_done   (burst_done),
      .idle_expired (idle_expired),
      .load         (load),
      .load_count   (load_count),
      .pop          (pop),
      .pop_last     (pop_last)
   );

   beat_framer u_framer (
      .clk        (clk),
      .reset      (reset),
      .rd_valid   (rd_valid),
      .rd_data    (rd_data),
      .pop_last   (pop_last),
      .beat_valid (beat_valid),
      .beat       (beat)
   );

endmodule : fifo_burst_drain

`default_nettype wire

// ==== logic/fifo_burst_pkg.sv ====
// package with the data word width, the output beat struct and the drain state enum
`default_nettype none

package fifo_burst_pkg;

   // ==============================
   // data word
   // ==============================

   // width of one host word, the beat payload is the same size
   localparam int WORD_W = 32;

   // ==============================
   // output beat
   // ==============================

   // one beat leaving the drain side
   // data sits in the upper bits and the last tag in bit 0, 33 bits in all
   typedef struct packed {
      logic [WORD_W-1:0] data;  // word as it was pushed by the host
      logic              last;  // set only on the final beat of a burst
   } beat_t;

   // ==============================
   // drain controller states
   // ==============================

   // FLUSH_WAIT still pops like BURST
   // it only remembers that a flush came in while the burst was running
   typedef enum logic [1:0] {
      IDLE       = 2'd0,  // no burst running, watching the three burst causes
      BURST      = 2'd1,  // one pop per cycle until the counter reports the last one
      FLUSH_WAIT = 2'd2   // same as BURST with a flush waiting to be served
   } drain_state_e;

endpackage : fifo_burst_pkg

`default_nettype wire

// ==== logic/sync_fifo.sv ====
// synchronous FIFO with masked enables, reset-busy window, level count and read latency 1
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
   parameter int FIFO_DEPTH = 16  // number of words, must be a power of two
) (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              push,       // host write request
   input  logic [fifo_burst_pkg::WORD_W-1:0] push_data,
   input  logic                              pop,        // read request from the drain side
   output logic [fifo_burst_pkg::WORD_W-1:0] rd_data,    // word of the pop one cycle back
   output logic                              rd_valid,   // strobe for rd_data
   output logic                              full,
   output logic                              empty,
   output logic [$clog2(FIFO_DEPTH):0]       level,      // words stored right now
   output logic                              busy        // reset-busy window
);
   import fifo_burst_pkg::*;

   localparam int AW = $clog2(FIFO_DEPTH);  // pointer width, wraps on its own
   localparam int LW = AW + 1;              // count needs one more bit to hold the full depth
   localparam logic [LW-1:0] DEPTH_LVL = LW'(FIFO_DEPTH);
   localparam logic [2:0] BUSY_CYCLES = 3'd4;  // length of the reset-busy window

   logic [WORD_W-1:0] mem [FIFO_DEPTH];  // plain register array
   logic [AW-1:0]     wr_ptr;
   logic [AW-1:0]     rd_ptr;
   logic [LW-1:0]     count;
   logic [2:0]        busy_cnt;
   logic              wr_en;  // push that really goes in
   logic              rd_en;  // pop that really comes out

   // ==============================
   // reset busy
   // ==============================

   // the counter loads during reset and runs down over the first four cycles after it
   always_ff @(posedge clk) begin
      if (reset) begin
         busy_cnt <= BUSY_CYCLES;
      end else if (busy_cnt != 3'd0) begin
         busy_cnt <= busy_cnt - 3'd1;
      end
   end

   assign busy = (busy_cnt != 3'd0);

   // both flags read 1 while busy so that neither side tries to move data
   assign full  = busy | (count == DEPTH_LVL);
   assign empty = busy | (count == '0);
   assign level = count;

   // requests are masked by status here, so the callers may ask at any time
   assign wr_en = ~busy & push & ~full;
   assign rd_en = ~busy & pop & ~empty;

   // ==============================
   // storage and pointers
   // ==============================

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + AW'(1);
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + AW'(1);
         end
         // a push and a pop in the same cycle leave the count where it is
         case ({wr_en, rd_en})
            2'b10:   count <= count + LW'(1);
            2'b01:   count <= count - LW'(1);
            default: count <= count;
         endcase
      end
   end

   // ==============================
   // read port
   // ==============================

   // word and strobe both appear one cycle after the accepted pop
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_data <= mem[rd_ptr];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= rd_en;  // one cycle of read latency
      end
   end

endmodule : sync_fifo

`default_nettype wire

// ==== tests/fifo_burst_drain_tb.sv ====
// testbench with the step table, the queue model of expected beats, the checks and the timeout
`timescale 1ns/1ns
`default_nettype none

module fifo_burst_drain_tb;
   import fifo_burst_pkg::*;

   localparam int FIFO_DEPTH = 16;
   localparam int BURST_LEN  = 4;
   localparam int IDLE_LIMIT = 12;
   localparam int NSTEPS     = 7;

   // one row of the stimulus table
   typedef struct packed {
      int n_push;     // back to back pushes
      bit flush;      // flush pulse right after the pushes
      int gap;        // quiet cycles after that
      int exp_beats;  // words accepted and sent out or -1 to leave it to the model
      int exp_lasts;  // bursts in the step or -1 to skip the check
      bit drops;      // some pushes must be dropped
   } step_t;

   logic              clk;
   logic              reset;
   logic              push;
   logic [WORD_W-1:0] push_data;
   logic              flush;
   logic              full;
   logic              beat_valid;
   beat_t             beat;
   drain_state_e      fsm_state;  // FSM state shown in the log lines

   step_t             steps [NSTEPS];
   logic [WORD_W-1:0] model_q [$];  // accepted words still owed as beats
   int                errors;
   int                checks;
   int                tests_failed;
   int                cycles;
   int                cycle_limit;
   int                step_accepted;
   int                step_dropped;
   int                step_beats;
   int                step_lasts;
   bit                push_done;      // no more pushes in the running step

   fifo_burst_drain #(
      .FIFO_DEPTH (FIFO_DEPTH),
      .BURST_LEN  (BURST_LEN),
      .IDLE_LIMIT (IDLE_LIMIT)
   ) UUT (
      .clk        (clk),
      .reset      (reset),
      .push       (push),
      .push_data  (push_data),
      .flush      (flush),
      .full       (full),
      .beat_valid (beat_valid),
      .beat       (beat)
   );

   assign fsm_state = UUT.u_fsm.state;

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;  // 8 ns period
   end

   // ==============================
   // cycle limit
   // ==============================

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout after %0d cycles with %0d beats still owed", cycles, model_q.size());
         $display("Verification failed");
         $finish;
      end
   end

   // ==============================
   // reference model and beat checks
   // ==============================

   // sampling on the falling edge keeps half a cycle away from every input and register change
   always @(negedge clk) begin : monitor
      logic [WORD_W-1:0] exp_data;
      bit                exp_last;
      if (!reset && push && !full) begin
         model_q.push_back(push_data);  // the FIFO takes it at the next rising edge
         step_accepted++;
      end else if (!reset && push) begin
         step_dropped++;  // full was high so the word is lost
      end
      if (!reset && beat_valid) begin
         checks++;
         step_beats++;  // every beat counts here including a stray one
         assert (model_q.size() != 0) else begin
            $display("FAIL %0t: beat %h arrived with no word pending", $time, beat.data);
            errors++;
         end
         if (beat.last) begin
            step_lasts++;
         end
         if (model_q.size() != 0) begin
            exp_data = model_q.pop_front();
            // whole bursts close every BURST_LEN beats and the remainder on the final word
            exp_last = (step_beats % BURST_LEN == 0) ||
                       (push_done && step_beats == step_accepted);
            checks += 2;
            assert (beat.data == exp_data) else begin
               $display("FAIL %0t: beat %0d data %h, expected %h",
                        $time, step_beats, beat.data, exp_data);
               errors++;
            end
            assert (beat.last == exp_last) else begin
               $display("FAIL %0t: beat %0d last %b, expected %b",
                        $time, step_beats, beat.last, exp_last);
               errors++;
            end
         end
      end
   end

   task automatic check_value(input string what, input int got, input int exp);
      checks++;
      assert (got == exp) else begin
         $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
         errors++;
      end
   endtask

   function automatic string step_name(input int idx);
      case (idx)
         0: return "reset busy";
         1: return "full bursts";
         2: return "flush";
         3: return "idle timeout";
         4: return "flush on empty";
         5: return "flush during burst";
         6: return "overflow";
         default: return "unnamed";
      endcase
   endfunction

   // ==============================
   // step driver
   // ==============================

   task automatic run_step(input int idx);
      step_t s;
      int    err_start;
      s             = steps[idx];
      err_start     = errors;
      step_accepted = 0;
      step_dropped  = 0;
      step_beats    = 0;
      step_lasts    = 0;
      push_done     = 1'b0;
      for (int i = 0; i < s.n_push; i++) begin
         push      <= 1'b1;
         push_data <= $urandom;
         @(posedge clk);
      end
      push      <= 1'b0;
      push_done  = 1'b1;  // accepted count of the step is final from here on
      if (s.flush) begin
         flush <= 1'b1;  // one-cycle pulse
         @(posedge clk);
         flush <= 1'b0;
      end
      repeat (s.gap) @(posedge clk);
      // a flush drains at once while the idle timer would need longer than the gap
      if (s.flush && s.n_push != 0) begin
         check_value("words owed after the flush", model_q.size(), 0);
      end
      while (model_q.size() != 0) @(posedge clk);  // wait for the last owed beat
      repeat (BURST_LEN) @(posedge clk);            // room for a stray beat to show up
      if (s.exp_beats >= 0) begin
         check_value("accepted pushes", step_accepted, s.exp_beats);
      end
      check_value("beats sent", step_beats, step_accepted);
      if (s.exp_lasts >= 0) begin
         check_value("last tags", step_lasts, s.exp_lasts);
      end
      checks++;
      assert ((step_dropped != 0) == s.drops) else begin
         $display("FAIL %0t: %0d pushes dropped, drops expected %b", $time, step_dropped, s.drops);
         errors++;
      end
      if (errors != err_start) begin
         tests_failed++;
      end
      $display("test %0d %s: %0d accepted, %0d dropped, %0d beats, %0d lasts, fsm %s, %s",
               idx + 1, step_name(idx), step_accepted, step_dropped, step_beats, step_lasts,
               fsm_state.name(), (errors == err_start) ? "ok" : "errors");
   endtask

   initial begin
      void'($urandom(37));  // one seed for the whole run
      reset        = 1'b1;
      push         = 1'b0;
      push_data    = '0;
      flush        = 1'b0;
      errors       = 0;
      checks       = 0;
      tests_failed = 0;
      cycles       = 0;
      cycle_limit  = 200;
      // pushes, flush, gap, expected beats, expected lasts, drops
      steps[0] = '{4, 1'b0, 20, 0, 0, 1'b1};       // pushes land in the reset-busy window
      steps[1] = '{8, 1'b0, 4, 8, 2, 1'b0};
      steps[2] = '{3, 1'b1, 10, 3, 1, 1'b0};
      steps[3] = '{2, 1'b0, 24, 2, 1, 1'b0};       // gap longer than IDLE_LIMIT
      steps[4] = '{0, 1'b1, 6, 0, 0, 1'b0};
      steps[5] = '{6, 1'b1, 10, 6, 2, 1'b0};       // flush lands inside the first burst
      steps[6] = '{120, 1'b0, 30, -1, -1, 1'b1};   // pushes outrun the drain of 4 per 5 cycles
      for (int i = 0; i < NSTEPS; i++) begin
         cycle_limit += (steps[i].n_push + int'(steps[i].flush) + steps[i].gap) * 4;
      end
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      for (int i = 0; i < NSTEPS; i++) begin
         run_step(i);
      end
      $display("tests %0d, tests with errors %0d, checks %0d, errors %0d",
               NSTEPS, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule : fifo_burst_drain_tb

`default_nettype wire
